//--- all.f
+incdir+rtl
rtl/rom_pkg.sv
rtl/ctrl_pkg.sv
rtl/rom_download.sv
rtl/rom_store.sv
rtl/key_decoder.sv
rtl/arcade_shell.sv
dv/arcade_shell_tb.sv

//--- dv/arcade_shell_tb.sv
`timescale 1ns/1ps

`include "arcade_defines.svh"

module arcade_shell_tb import rom_pkg::*; ();

	localparam int CPU_BYTES = `SND_BASE;
	localparam int SND_BYTES = 2 * `SND_WORDS;
	localparam int IMG_BYTES = CPU_BYTES + SND_BYTES;  // 48 KiB image
	// Download takes up to 6 cycles a byte and readback one more
	localparam int WATCH_CYCLES = IMG_BYTES * 8 + 4000;

	logic                   clk_sys;
	logic                   rst_n;
	logic                   ioctl_download;
	logic                   ioctl_wr;
	logic [`ROM_ADDR_W-1:0] ioctl_addr;
	logic [7:0]             ioctl_dout;
	logic                   status_reset;
	logic                   button_reset;
	logic                   key_strobe;
	logic                   key_pressed;
	logic [7:0]             key_code;
	logic [7:0]             joystick_0;
	logic [7:0]             joystick_1;
	logic [`CPU_ADDR_W-1:0] cpu_rom_addr;
	logic [`SND_ADDR_W-1:0] snd_rom_addr;
	logic [7:0]             cpu_rom_byte;
	logic [7:0]             snd_rom_byte;
	logic                   rom_loaded;
	logic                   core_reset;
	logic                   up;
	logic                   down;
	logic                   left;
	logic                   right;
	logic                   fire;
	logic                   coin;
	logic                   start1;
	logic                   start2;

	integer     seed = 99394;
	logic [7:0] image [IMG_BYTES];  // Reference ROM image
	int         errors;
	int         writes_sent;
	int         wr_seen;            // Store write pulses seen
	logic       rd_cpu;             // Readback requests from the stimulus
	logic       rd_snd;
	logic       cpu_pend;
	logic       snd_pend;
	int         cpu_addr_q;
	int         snd_addr_q;
	logic [7:0] shadow;             // {up,down,left,right,fire,coin,start1,start2}

	arcade_shell DUT (.*);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	// ==================================================
	// Reference model
	// ==================================================
	function automatic logic [7:0] ref_rom_byte(input rom_region_t region, input int addr);
		if (region == REGION_CPU)
			return image[16'(addr)];
		return image[16'(`SND_BASE + addr)];  // Sound ROM follows the CPU ROM
	endfunction

	function automatic logic [7:0] next_keys(input logic [7:0] keys, input logic [7:0] code,
	                                         input logic pressed);
		logic [7:0] k;
		k = keys;
		case (code)
			`KEY_UP:     k[7] = pressed;
			`KEY_DOWN:   k[6] = pressed;
			`KEY_LEFT:   k[5] = pressed;
			`KEY_RIGHT:  k[4] = pressed;
			`KEY_FIRE:   k[3] = pressed;
			`KEY_COIN:   k[2] = pressed;
			`KEY_START1: k[1] = pressed;
			`KEY_START2: k[0] = pressed;
			default:     ;
		endcase
		return k;
	endfunction

	// Directions and fire also come from either joystick
	function automatic logic [7:0] ref_ctrl(input logic [7:0] keys, input logic [7:0] j0,
	                                        input logic [7:0] j1);
		logic [7:0] j;
		j = j0 | j1;
		return {keys[7] | j[3], keys[6] | j[2], keys[5] | j[1], keys[4] | j[0],
		        keys[3] | j[4], keys[2:0]};
	endfunction

	function automatic logic [7:0] mapped_code(input int sel);
		case (sel)
			0:       return `KEY_UP;
			1:       return `KEY_DOWN;
			2:       return `KEY_LEFT;
			3:       return `KEY_RIGHT;
			4:       return `KEY_COIN;
			5:       return `KEY_START1;
			6:       return `KEY_START2;
			default: return `KEY_FIRE;
		endcase
	endfunction

	// ==================================================
	// Checks
	// ==================================================
	task automatic report_error(input string msg);
		errors++;
		$display("%s", msg);
		$display("SIMULATION FAILED");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic check_val(input string name, input logic [7:0] exp, input logic [7:0] act);
		assert (act === exp)
		else report_error($sformatf("Fail at %0t: %s expected %h actual %h",
		                            $time, name, exp, act));
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		assert (act === exp)
		else report_error($sformatf("Fail at %0t: %s expected %b actual %b",
		                            $time, name, exp, act));
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		assert (act == exp)
		else report_error($sformatf("Fail at %0t: %s expected %0d actual %0d",
		                            $time, name, exp, act));
	endtask

	task automatic next_slot();
		@(negedge clk_sys);
		#2;  // Outputs settled, inputs not yet changing
	endtask

	// ==================================================
	// Stimulus tasks
	// ==================================================
	task automatic write_byte(input int addr, input logic [7:0] data, input int hold);
		@(negedge clk_sys);
		ioctl_addr = 16'(addr);
		ioctl_dout = data;
		ioctl_wr   = 1'b1;
		repeat (hold - 1) @(negedge clk_sys);  // Strobe high for hold cycles
		@(negedge clk_sys);
		ioctl_wr = 1'b0;
		repeat (2) @(negedge clk_sys);  // Three low cycles
		writes_sent++;
	endtask

	task automatic read_range(input rom_region_t region, input int first, input int count);
		for (int a = first; a < first + count; a++) begin
			@(negedge clk_sys);
			if (region == REGION_CPU) begin
				cpu_rom_addr = 15'(a);
				rd_cpu       = 1'b1;
			end else begin
				snd_rom_addr = 14'(a);
				rd_snd       = 1'b1;
			end
		end
		@(negedge clk_sys);
		rd_cpu = 1'b0;
		rd_snd = 1'b0;
	endtask

	task automatic pulse_reset(input logic use_button);
		@(negedge clk_sys);
		status_reset = ~use_button;
		button_reset = use_button;
		#2;
		check_bit("core_reset", 1'b0, core_reset);
		@(negedge clk_sys);
		status_reset = 1'b0;
		button_reset = 1'b0;
		#2;
		check_bit("core_reset", 1'b1, core_reset);
		next_slot();
		check_bit("core_reset", 1'b0, core_reset);
	endtask

	// ==================================================
	// Compare process
	// ==================================================
	initial begin
		cpu_pend = 1'b0;
		snd_pend = 1'b0;
		shadow   = 8'h00;
		wr_seen  = 0;
		forever begin
			next_slot();
			if (rst_n) begin
				check_val("up/down/left/right/fire/coin/start1/start2",
				          ref_ctrl(shadow, joystick_0, joystick_1),
				          {up, down, left, right, fire, coin, start1, start2});
				if (key_strobe)
					shadow = next_keys(shadow, key_code, key_pressed);  // Latched at next edge
				if (cpu_pend)
					check_val("cpu_rom_byte", ref_rom_byte(REGION_CPU, cpu_addr_q), cpu_rom_byte);
				if (snd_pend)
					check_val("snd_rom_byte", ref_rom_byte(REGION_SND, snd_addr_q), snd_rom_byte);
				cpu_pend   = rd_cpu;
				snd_pend   = rd_snd;
				cpu_addr_q = int'(cpu_rom_addr);
				snd_addr_q = int'(snd_rom_addr);
				if (DUT.cpu_wr || DUT.snd_wr)
					wr_seen++;
			end
		end
	end

	initial begin
		repeat (WATCH_CYCLES) @(posedge clk_sys);
		report_error($sformatf("Timeout: tests still running after %0d cycles", WATCH_CYCLES));
	end

	// ==================================================
	// Test sequence
	// ==================================================
	initial begin
		int         base;
		logic [7:0] nb;
		errors = 0;
		writes_sent = 0;
		rst_n = 1'b0;
		ioctl_download = 1'b0;
		ioctl_wr = 1'b0;
		ioctl_addr = '0;
		ioctl_dout = 8'h00;
		status_reset = 1'b0;
		button_reset = 1'b0;
		key_strobe = 1'b0;
		key_pressed = 1'b0;
		key_code = 8'h00;
		joystick_0 = 8'h00;
		joystick_1 = 8'h00;
		cpu_rom_addr = '0;
		snd_rom_addr = '0;
		rd_cpu = 1'b0;
		rd_snd = 1'b0;
		for (int i = 0; i < IMG_BYTES; i++)
			image[16'(i)] = 8'($random(seed));
		repeat (8) @(negedge clk_sys);
		rst_n = 1'b1;

		next_slot();
		check_bit("core_reset", 1'b1, core_reset);
		check_bit("rom_loaded", 1'b0, rom_loaded);

		// Full image download, then drop the download level
		@(negedge clk_sys);
		ioctl_download = 1'b1;
		for (int a = 0; a < IMG_BYTES; a++)
			write_byte(a, image[16'(a)], 1 + ({$random(seed)} % 3));
		@(negedge clk_sys);
		check_count("store writes", writes_sent, wr_seen);
		check_bit("core_reset", 1'b1, core_reset);
		ioctl_download = 1'b0;
		next_slot();
		check_bit("rom_loaded", 1'b0, rom_loaded);
		next_slot();
		check_bit("rom_loaded", 1'b0, rom_loaded);
		next_slot();
		check_bit("rom_loaded", 1'b1, rom_loaded);  // Third edge after the drop
		check_bit("core_reset", 1'b1, core_reset);
		next_slot();
		check_bit("core_reset", 1'b0, core_reset);

		read_range(REGION_CPU, 0, CPU_BYTES);
		read_range(REGION_SND, 0, SND_BYTES);
		pulse_reset(1'b0);
		pulse_reset(1'b1);

		// Keyboard events, some of them unmapped
		for (int k = 0; k < 200; k++) begin
			@(negedge clk_sys);
			key_strobe  = 1'b1;
			key_pressed = ($random(seed) & 1) != 0;
			if (($random(seed) & 1) != 0)
				key_code = mapped_code({$random(seed)} % 8);
			else
				key_code = 8'($random(seed));
			@(negedge clk_sys);
			key_strobe = 1'b0;
			repeat ({$random(seed)} % 3) @(negedge clk_sys);
		end

		// Rewrite the first bytes with the strobe held for 3 cycles
		base = wr_seen;
		@(negedge clk_sys);
		ioctl_download = 1'b1;
		for (int a = 0; a < 6; a++) begin
			nb = image[16'(a)] ^ (8'h01 | 8'($random(seed)));  // Always a new value
			image[16'(a)] = nb;
			write_byte(a, nb, 3);
		end
		@(negedge clk_sys);
		ioctl_download = 1'b0;
		check_count("store writes in rewrite", 6, wr_seen - base);
		repeat (4) @(negedge clk_sys);
		read_range(REGION_CPU, 0, 7);
		check_bit("rom_loaded", 1'b1, rom_loaded);

		// Joystick merge with an occasional key event
		for (int k = 0; k < 100; k++) begin
			@(negedge clk_sys);
			joystick_0  = 8'($random(seed));
			joystick_1  = 8'($random(seed));
			key_strobe  = (k % 4) == 0;
			key_pressed = ($random(seed) & 1) != 0;
			key_code    = mapped_code({$random(seed)} % 8);
		end
		@(negedge clk_sys);
		key_strobe = 1'b0;
		joystick_0 = 8'h00;
		joystick_1 = 8'h00;
		repeat (2) @(negedge clk_sys);

		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

//--- rtl/arcade_defines.svh
`ifndef ARCADE_DEFINES_SVH
`define ARCADE_DEFINES_SVH

// ==================================================
// ROM image layout
// ==================================================
`define ROM_ADDR_W  16     // Download byte address, 48 KiB image
`define CPU_ADDR_W  15     // Main CPU ROM byte address
`define SND_ADDR_W  14     // Sound board ROM byte address
`define SND_BASE    32768  // First download byte of the sound ROM
`define CPU_WORDS   16384
`define SND_WORDS   8192

// ==================================================
// Keyboard scan codes
// ==================================================
`define KEY_UP      8'h75
`define KEY_DOWN    8'h72
`define KEY_LEFT    8'h6B
`define KEY_RIGHT   8'h74
`define KEY_COIN    8'h76  // ESC
`define KEY_START1  8'h05  // F1
`define KEY_START2  8'h06  // F2
`define KEY_FIRE    8'h29  // Space

`endif

//--- rtl/arcade_shell.sv
`timescale 1ns/1ps

`include "arcade_defines.svh"

module arcade_shell import rom_pkg::*, ctrl_pkg::*; (
	input  logic                    clk_sys,
	input  logic                    rst_n,
	// Loader
	input  logic                    ioctl_download,
	input  logic                    ioctl_wr,
	input  logic [`ROM_ADDR_W-1:0]  ioctl_addr,
	input  rom_byte_t               ioctl_dout,
	// Reset sources
	input  logic                    status_reset,
	input  logic                    button_reset,
	// Keyboard and joysticks
	input  logic                    key_strobe,
	input  logic                    key_pressed,
	input  scan_code_t              key_code,
	input  joy_t                    joystick_0,
	input  joy_t                    joystick_1,
	// Game core ROM ports
	input  logic [`CPU_ADDR_W-1:0]  cpu_rom_addr,
	input  logic [`SND_ADDR_W-1:0]  snd_rom_addr,
	output rom_byte_t               cpu_rom_byte,
	output rom_byte_t               snd_rom_byte,
	// Game core control
	output logic                    rom_loaded,
	output logic                    core_reset,
	output logic                    up,
	output logic                    down,
	output logic                    left,
	output logic                    right,
	output logic                    fire,
	output logic                    coin,
	output logic                    start1,
	output logic                    start2
);

	logic                   cpu_wr;
	logic                   snd_wr;
	logic [`CPU_ADDR_W-2:0] wr_word_addr;
	byte_en_t               wr_be;
	rom_byte_t              wr_byte;

	// ==================================================
	// Download path
	// ==================================================
	rom_download u_rom_download (
		.clk_sys        (clk_sys),
		.rst_n          (rst_n),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.status_reset   (status_reset),
		.button_reset   (button_reset),
		.cpu_wr         (cpu_wr),
		.snd_wr         (snd_wr),
		.wr_word_addr   (wr_word_addr),
		.wr_be          (wr_be),
		.wr_byte        (wr_byte),
		.rom_loaded     (rom_loaded),
		.core_reset     (core_reset)
	);

	// ==================================================
	// Word stores
	// ==================================================
	rom_store #(
		.DEPTH  (`CPU_WORDS),
		.ADDR_W (`CPU_ADDR_W)
	) cpu_rom (
		.clk_sys (clk_sys),
		.wr_en   (cpu_wr),
		.wr_addr (wr_word_addr),
		.wr_be   (wr_be),
		.wr_byte (wr_byte),
		.rd_addr (cpu_rom_addr),
		.rd_byte (cpu_rom_byte)
	);

	rom_store #(
		.DEPTH  (`SND_WORDS),
		.ADDR_W (`SND_ADDR_W)
	) snd_rom (
		.clk_sys (clk_sys),
		.wr_en   (snd_wr),
		.wr_addr (wr_word_addr[`SND_ADDR_W-2:0]),  // Sound store is half as deep
		.wr_be   (wr_be),
		.wr_byte (wr_byte),
		.rd_addr (snd_rom_addr),
		.rd_byte (snd_rom_byte)
	);

	// Player controls
	key_decoder u_key_decoder (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.key_strobe  (key_strobe),
		.key_pressed (key_pressed),
		.key_code    (key_code),
		.joystick_0  (joystick_0),
		.joystick_1  (joystick_1),
		.up          (up),
		.down        (down),
		.left        (left),
		.right       (right),
		.fire        (fire),
		.coin        (coin),
		.start1      (start1),
		.start2      (start2)
	);

endmodule

//--- rtl/ctrl_pkg.sv
package ctrl_pkg;

	// Keyboard scan code as reported by the key strobe
	typedef logic [7:0] scan_code_t;

	// Joystick vector, bit 0 is right
	// Upper three bits carry extra buttons that the game does not use
	typedef struct packed {
		logic [2:0] spare;
		logic       fire;   // bit 4
		logic       up;     // bit 3
		logic       down;   // bit 2
		logic       left;   // bit 1
		logic       right;  // bit 0
	} joy_t;

	// Number of player controls driven towards the game core
	localparam int unsigned NUM_CONTROLS = 8;

	typedef logic [NUM_CONTROLS-1:0] ctrl_vec_t;

endpackage

//--- rtl/key_decoder.sv
`timescale 1ns/1ps

`include "arcade_defines.svh"

module key_decoder import ctrl_pkg::*; (
	input  logic       clk_sys,
	input  logic       rst_n,
	input  logic       key_strobe,
	input  logic       key_pressed,
	input  scan_code_t key_code,
	input  joy_t       joystick_0,
	input  joy_t       joystick_1,
	output logic       up,
	output logic       down,
	output logic       left,
	output logic       right,
	output logic       fire,
	output logic       coin,
	output logic       start1,
	output logic       start2
);

	logic key_up;
	logic key_down;
	logic key_left;
	logic key_right;
	logic key_fire;
	logic key_coin;
	logic key_start1;
	logic key_start2;

	// ==================================================
	// Key state latches
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			key_up     <= 1'b0;
			key_down   <= 1'b0;
			key_left   <= 1'b0;
			key_right  <= 1'b0;
			key_fire   <= 1'b0;
			key_coin   <= 1'b0;
			key_start1 <= 1'b0;
			key_start2 <= 1'b0;
		end else if (key_strobe) begin
			// Press sets, release clears
			case (key_code)
				`KEY_UP:     key_up     <= key_pressed;
				`KEY_DOWN:   key_down   <= key_pressed;
				`KEY_LEFT:   key_left   <= key_pressed;
				`KEY_RIGHT:  key_right  <= key_pressed;
				`KEY_FIRE:   key_fire   <= key_pressed;
				`KEY_COIN:   key_coin   <= key_pressed;
				`KEY_START1: key_start1 <= key_pressed;
				`KEY_START2: key_start2 <= key_pressed;
				default:     ;  // Unmapped key
			endcase
		end
	end

	// ==================================================
	// Merge with both joysticks
	// ==================================================
	assign up    = key_up    | joystick_0.up    | joystick_1.up;
	assign down  = key_down  | joystick_0.down  | joystick_1.down;
	assign left  = key_left  | joystick_0.left  | joystick_1.left;
	assign right = key_right | joystick_0.right | joystick_1.right;
	assign fire  = key_fire  | joystick_0.fire  | joystick_1.fire;

	assign coin   = key_coin;    // Keyboard only
	assign start1 = key_start1;
	assign start2 = key_start2;

endmodule

//--- rtl/rom_download.sv
`timescale 1ns/1ps

`include "arcade_defines.svh"

module rom_download import rom_pkg::*; (
	input  logic                    clk_sys,
	input  logic                    rst_n,
	input  logic                    ioctl_download,
	input  logic                    ioctl_wr,
	input  logic [`ROM_ADDR_W-1:0]  ioctl_addr,
	input  rom_byte_t               ioctl_dout,
	input  logic                    status_reset,
	input  logic                    button_reset,
	output logic                    cpu_wr,
	output logic                    snd_wr,
	output logic [`CPU_ADDR_W-2:0]  wr_word_addr,
	output byte_en_t                wr_be,
	output rom_byte_t               wr_byte,
	output logic                    rom_loaded,
	output logic                    core_reset
);

	logic                   wr_q;     // ioctl_wr sampled
	logic                   wr_qq;
	logic                   dl_q;     // Download level sampled
	logic                   dl_d1;
	logic                   dl_d2;
	logic [`ROM_ADDR_W-1:0] addr_q;
	rom_byte_t              dout_q;

	logic                   wr_rise;
	logic                   dl_fall;
	rom_region_t            region;
	logic [`CPU_ADDR_W-2:0] word_src;

	// ==================================================
	// Input sampling
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			wr_q  <= 1'b0;
			wr_qq <= 1'b0;
			dl_q  <= 1'b0;
			dl_d1 <= 1'b0;
			dl_d2 <= 1'b0;
		end else begin
			wr_q  <= ioctl_wr;
			wr_qq <= wr_q;
			dl_q  <= ioctl_download;
			dl_d1 <= dl_q;
			dl_d2 <= dl_d1;
		end
	end

	always_ff @(posedge clk_sys) begin
		addr_q <= ioctl_addr;
		dout_q <= ioctl_dout;
	end

	assign wr_rise = wr_q & ~wr_qq & dl_q;  // One pulse per strobe edge
	assign dl_fall = dl_d2 & ~dl_d1;

	// Sound bytes are rebased to the start of their own store
	assign region   = (addr_q < `ROM_ADDR_W'(`SND_BASE)) ? REGION_CPU : REGION_SND;
	assign word_src = addr_q[`CPU_ADDR_W-1:1];  // Top bit dropped, SND_BASE lands on word 0

	// ==================================================
	// Write toward the stores
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			cpu_wr <= 1'b0;
			snd_wr <= 1'b0;
		end else begin
			cpu_wr <= wr_rise & (region == REGION_CPU);
			snd_wr <= wr_rise & (region == REGION_SND);
		end
	end

	always_ff @(posedge clk_sys) begin
		if (wr_rise) begin
			wr_word_addr <= word_src;
			wr_be        <= lane_of(addr_q[0]);  // Both regions start on an even byte
			wr_byte      <= dout_q;
		end
	end

	// ==================================================
	// Load flag and game core reset
	// ==================================================
	// Loaded two edges after the download level is first seen low
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			rom_loaded <= 1'b0;
			core_reset <= 1'b1;
		end else begin
			if (dl_fall)
				rom_loaded <= 1'b1;
			core_reset <= status_reset | button_reset | ~rom_loaded;
		end
	end

endmodule

//--- rtl/rom_pkg.sv
package rom_pkg;

	// Stored word, lower-addressed byte in bits 7:0
	typedef logic [15:0] rom_word_t;

	// One data byte, as delivered by the loader and read by the core
	typedef logic [7:0] rom_byte_t;

	// Lane enable for a word write
	// bit 1 selects the high byte, bit 0 the low byte
	typedef logic [1:0] byte_en_t;

	// Which store a download byte belongs to
	typedef enum logic {
		REGION_CPU = 1'b0,  // Main CPU program ROM
		REGION_SND = 1'b1   // Sound board ROM
	} rom_region_t;

	// Lane for a byte address, picked by its bit 0
	function automatic byte_en_t lane_of(input logic addr_lsb);
		return addr_lsb ? 2'b10 : 2'b01;
	endfunction

endpackage

//--- rtl/rom_store.sv
`timescale 1ns/1ps

module rom_store import rom_pkg::*; #(
	parameter int unsigned DEPTH  = 16384,  // Words
	parameter int unsigned ADDR_W = 15      // Byte address width
) (
	input  logic              clk_sys,
	input  logic              wr_en,
	input  logic [ADDR_W-2:0] wr_addr,
	input  byte_en_t          wr_be,
	input  rom_byte_t         wr_byte,
	input  logic [ADDR_W-1:0] rd_addr,
	output rom_byte_t         rd_byte
);

	rom_word_t mem [DEPTH];

	rom_word_t rd_word;
	logic      rd_lane;  // Address bit 0 of the word held in rd_word

	// ==================================================
	// Byte-lane write
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (wr_en) begin
			if (wr_be[0])
				mem[wr_addr][7:0] <= wr_byte;
			if (wr_be[1])
				mem[wr_addr][15:8] <= wr_byte;
		end
	end

	// ==================================================
	// Registered read
	// ==================================================
	always_ff @(posedge clk_sys) begin
		rd_word <= mem[rd_addr[ADDR_W-1:1]];
		rd_lane <= rd_addr[0];
	end

	// Odd bytes live in the high half
	assign rd_byte = rd_lane ? rd_word[15:8] : rd_word[7:0];

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the arcade shell testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -f sim.log

verilator --binary --assert \
	--top-module arcade_shell_tb \
	-f all.f \
	--Mdir obj_dir \
	-o arcade_sim

# The log decides the result
./obj_dir/arcade_sim | tee sim.log

if grep -q "SIMULATION FAILED" sim.log; then
	echo "run_sim: failure reported in sim.log"
	exit 1
fi

echo "run_sim: no failure reported in sim.log"
